// ==== alu.sv ====
`default_nettype none

module alu
    import exec_pkg::*;
#(
    parameter int DATA_W = 32
) (
    alu_if.alu bus
);

    logic [DATA_W-1:0] add_a;
    logic [DATA_W-1:0] add_b;
    logic [DATA_W-1:0] add_sum;
    logic              add_cout;
    logic [DATA_W-1:0] ofs_b;
    logic [DATA_W-1:0] ofs_sum;

    // ----------------------------------------------------------
    // adders
    // ----------------------------------------------------------
    // negate reuses the main adder as ~a + 1
    assign add_a = bus.negate ? ~bus.a : bus.a;
    assign add_b = bus.negate ? DATA_W'(1) : bus.b;

    cla_adder_32 #(
        .DATA_W (DATA_W)
    ) add_inst (
        .a    (add_a),
        .b    (add_b),
        .cin  (1'b0),
        .sum  (add_sum),
        .cout (add_cout)
    );

    assign ofs_b = {{(DATA_W-16){1'b0}}, bus.b[15:0]};  // offset is 16 bits

    cla_adder_32 #(
        .DATA_W (DATA_W)
    ) ofs_inst (
        .a    (bus.a),
        .b    (ofs_b),
        .cin  (1'b0),
        .sum  (ofs_sum),
        .cout ()
    );

    // ----------------------------------------------------------
    // function select
    // ----------------------------------------------------------
    always_comb begin
        case (bus.alu_op)
            OP_ADD, OP_NEG: bus.result = add_sum;
            OP_AND:         bus.result = bus.a & bus.b;
            OP_XOR:         bus.result = bus.a ^ bus.b;
            OP_SLL:         bus.result = bus.a << bus.b;  // full b as amount
            OP_SRL:         bus.result = bus.a >> bus.b;
            OP_SRA:         bus.result = DATA_W'($signed(bus.a) >>> bus.b);
            OP_PASS_A:      bus.result = bus.a;
            OP_PASS_B:      bus.result = bus.b;
            OP_MEM_OFS:     bus.result = ofs_sum;
            default:        bus.result = '0;
        endcase
    end

    assign bus.carry = add_cout;  // only taken on add
    assign bus.zero  = (bus.result == '0);
    assign bus.sign  = bus.result[DATA_W-1];

    // decoder must always present a defined function
    a_op_known: assert property (
        @(posedge bus.clk) disable iff (!bus.rst_n) !$isunknown(bus.alu_op)
    ) else $error("alu: function select has unknown bits");

endmodule

`default_nettype wire

// ==== alu_if.sv ====
`default_nettype none

interface alu_if #(
    parameter int DATA_W = 32
) (
    input logic clk,
    input logic rst_n
);

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [3:0]        alu_op;
    logic              negate;
    logic [DATA_W-1:0] result;
    logic              carry;
    logic              zero;
    logic              sign;

    modport decoder (
        output a, b, alu_op, negate
    );

    modport alu (
        input  clk, rst_n, a, b, alu_op, negate,
        output result, carry, zero, sign
    );

    // alu_op tells writeback whether carry is live
    modport writeback (
        input result, carry, zero, sign, alu_op
    );

endinterface

`default_nettype wire

// ==== cla_adder_32.sv ====
`default_nettype none

module cla_adder_32 #(
    parameter int DATA_W = 32
) (
    input  wire logic [DATA_W-1:0] a,
    input  wire logic [DATA_W-1:0] b,
    input  wire logic              cin,
    output logic      [DATA_W-1:0] sum,
    output logic                   cout
);

    localparam int GROUPS = DATA_W / 4;

    logic [DATA_W-1:0] g;        // bit generate
    logic [DATA_W-1:0] p;        // bit propagate
    logic [DATA_W-1:0] c;        // carry into each bit
    logic [GROUPS:0]   gc;       // carry into each group
    logic [GROUPS-1:0] grp_g;
    logic [GROUPS-1:0] grp_p;

    assign g     = a & b;
    assign p     = a ^ b;
    assign gc[0] = cin;

    // ----------------------------------------------------------
    // 4-bit lookahead groups
    // ----------------------------------------------------------
    for (genvar k = 0; k < GROUPS; k++) begin : g_group
        localparam int LSB = 4 * k;

        assign c[LSB]   = gc[k];
        assign c[LSB+1] = g[LSB] | (p[LSB] & gc[k]);
        assign c[LSB+2] = g[LSB+1] | (p[LSB+1] & g[LSB])
                        | (p[LSB+1] & p[LSB] & gc[k]);
        assign c[LSB+3] = g[LSB+2] | (p[LSB+2] & g[LSB+1])
                        | (p[LSB+2] & p[LSB+1] & g[LSB])
                        | (p[LSB+2] & p[LSB+1] & p[LSB] & gc[k]);

        // group terms feed the next group directly
        assign grp_g[k] = g[LSB+3] | (p[LSB+3] & g[LSB+2])
                        | (p[LSB+3] & p[LSB+2] & g[LSB+1])
                        | (p[LSB+3] & p[LSB+2] & p[LSB+1] & g[LSB]);
        assign grp_p[k] = &p[LSB+3:LSB];
        assign gc[k+1]  = grp_g[k] | (grp_p[k] & gc[k]);
    end

    assign sum  = p ^ c;
    assign cout = gc[GROUPS];

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`default_nettype none

module exec_core #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              instr_valid,
    input  wire logic [31:0]       instr,
    output logic      [DATA_W-1:0] result,
    output logic                   result_valid,
    output logic                   carry,
    output logic                   zero,
    output logic                   sign
);

    logic [REG_ADDR_W-1:0] raddr_a;
    logic [REG_ADDR_W-1:0] raddr_b;
    logic [DATA_W-1:0]     rdata_a;
    logic [DATA_W-1:0]     rdata_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wb_strobe;
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [DATA_W-1:0]     wdata;

    alu_if #(.DATA_W(DATA_W)) alu_bus (.clk(clk), .rst_n(rst_n));

    // ----------------------------------------------------------
    // read, decode, execute, write back
    // ----------------------------------------------------------
    reg_file #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    operand_decoder #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) operand_decoder_inst (
        .instr       (instr),      // raw word viewed as the union
        .instr_valid (instr_valid),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .rd          (rd),
        .wb_strobe   (wb_strobe),
        .bus         (alu_bus.decoder)
    );

    alu #(
        .DATA_W (DATA_W)
    ) alu_inst (
        .bus (alu_bus.alu)
    );

    writeback_reg #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) writeback_reg_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (alu_bus.writeback),
        .rd           (rd),
        .wb_strobe    (wb_strobe),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .result       (result),
        .result_valid (result_valid),
        .carry        (carry),
        .zero         (zero),
        .sign         (sign)
    );

endmodule

`default_nettype wire

// ==== exec_core_testdata.txt ====
// columns: instruction, expected result, carry, zero, sign (hex)
// one vector per line, carry changes only on add
C040FFFF 0000FFFF 0 0 0
39020000 0000FFFF 0 0 0
A0820010 FFFF0000 0 0 1
18C41000 FFFFFFFF 0 0 1
81460001 00000000 1 1 0
11861000 0000FFFF 1 0 0
99C400FF FFFF00FF 1 0 1
AA040004 0FFFF000 1 0 0
0A420000 FFFF0001 1 0 1
1A929000 00000000 1 1 0
A2C20000 0000FFFF 1 0 0
A2C2001F 80000000 1 0 1
A2C20028 00000000 1 1 0
AB040000 FFFF0000 1 0 1
AB04001F 00000001 1 0 0
AB040028 00000000 1 1 0
B3440000 FFFF0000 1 0 1
B344001F FFFFFFFF 1 0 1
B3440028 FFFFFFFF 1 0 1
B3420028 00000000 1 1 0
4B823000 0001FFFE 1 0 0
CB841234 FFFF1234 1 0 1
4BC82000 0000FFFF 1 0 0
C000BEEF 0000BEEF 1 0 0
3C000000 00000000 1 1 0
54463000 00000000 1 1 0
7C461000 00000000 1 1 0
04824000 0001FFFE 0 0 0
04C42000 FFFE0000 1 0 1
3D220000 00000000 1 1 0

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // ALU function codes 0..9 with 10..15 giving zero
    localparam logic [3:0] OP_ADD     = 4'd0;
    localparam logic [3:0] OP_NEG     = 4'd1;  // ~a + 1
    localparam logic [3:0] OP_AND     = 4'd2;
    localparam logic [3:0] OP_XOR     = 4'd3;
    localparam logic [3:0] OP_SLL     = 4'd4;
    localparam logic [3:0] OP_SRL     = 4'd5;
    localparam logic [3:0] OP_SRA     = 4'd6;
    localparam logic [3:0] OP_PASS_A  = 4'd7;
    localparam logic [3:0] OP_PASS_B  = 4'd8;
    localparam logic [3:0] OP_MEM_OFS = 4'd9;  // a + low half of b

    // bits left over below rt in register form
    localparam int R_UNUSED_W = DATA_W - 1 - 4 - 3 * REG_ADDR_W;

    typedef struct packed {
        logic                  imm_sel;
        logic [3:0]            alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [R_UNUSED_W-1:0] unused;
    } instr_r_t;

    typedef struct packed {
        logic                  imm_sel;
        logic [3:0]            alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic                  spare;
        logic [15:0]           imm16;
    } instr_i_t;

    // imm_sel picks the view
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== operand_decoder.sv ====
`default_nettype none

module operand_decoder
    import exec_pkg::*;
#(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire instr_u                instr,
    input  wire logic                  instr_valid,
    output logic      [REG_ADDR_W-1:0] raddr_a,
    output logic      [REG_ADDR_W-1:0] raddr_b,
    input  wire logic [DATA_W-1:0]     rdata_a,
    input  wire logic [DATA_W-1:0]     rdata_b,
    output logic      [REG_ADDR_W-1:0] rd,
    output logic                       wb_strobe,
    alu_if.decoder                     bus
);

    logic              imm_form;
    logic [DATA_W-1:0] imm_ext;

    // ----------------------------------------------------------
    // register addressing
    // ----------------------------------------------------------
    // rs, rd and the op sit at the same bits in both views
    assign imm_form = instr.r.imm_sel;
    assign raddr_a  = instr.r.rs;
    assign raddr_b  = imm_form ? '0 : instr.r.rt;  // rt slot is imm bits otherwise

    // ----------------------------------------------------------
    // operands to the ALU
    // ----------------------------------------------------------
    assign imm_ext = {{(DATA_W-16){1'b0}}, instr.i.imm16};

    assign bus.a      = rdata_a;
    assign bus.b      = imm_form ? imm_ext : rdata_b;
    assign bus.alu_op = instr.r.alu_op;
    assign bus.negate = (instr.r.alu_op == OP_NEG);

    // destination and strobe go straight to writeback
    assign rd        = instr.r.rd;
    assign wb_strobe = instr_valid;

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [REG_ADDR_W-1:0] raddr_a,
    input  wire logic [REG_ADDR_W-1:0] raddr_b,
    output logic      [DATA_W-1:0]     rdata_a,
    output logic      [DATA_W-1:0]     rdata_b,
    input  wire logic                  we,
    input  wire logic [REG_ADDR_W-1:0] waddr,
    input  wire logic [DATA_W-1:0]     wdata
);

    localparam int NREGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // holds across writes from writeback with rd = 0
    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raddr_a == '0 |-> rdata_a == '0) and (raddr_b == '0 |-> rdata_b == '0)
    ) else $error("reg_file: register 0 read back non-zero");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tb_exec_core &&
{ sim_out="$(./obj_dir/Vtb_exec_core 2>&1)"; printf '%s\n' "$sim_out"; \
  printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; } &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_exec_core.sv ====
`default_nettype none

module tb_exec_core
    import exec_pkg::*;
();

    localparam int MAX_VEC    = 64;
    localparam int FIELDS     = 5;   // instr, result, carry, zero, sign
    localparam int CLK_PERIOD = 10;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              instr_valid;
    logic [31:0]       instr;
    logic [DATA_W-1:0] result;
    logic              result_valid;
    logic              carry;
    logic              zero;
    logic              sign;

    logic [31:0] vec_mem [MAX_VEC*FIELDS];
    int          n_vec     = 0;
    logic        loaded    = 1'b0;
    logic [31:0] lfsr_state = 32'h9af0ad9d;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_core #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) exec_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result       (result),
        .result_valid (result_valid),
        .carry        (carry),
        .zero         (zero),
        .sign         (sign)
    );

    // ----------------------------------------------------------
    // checking helpers
    // ----------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at time %0t: %s expected %h, actual %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at time %0t: %s expected %b, actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_vector(input int v);
        int base;
        base = v * FIELDS;
        if (result_valid !== 1'b1) begin
            report_failure($sformatf("result_valid did not rise after instruction %0d (time %0t)",
                                     v, $time));
        end
        check_word("result", vec_mem[base+1], result);
        check_flag("carry", vec_mem[base+2][0], carry);
        check_flag("zero", vec_mem[base+3][0], zero);
        check_flag("sign", vec_mem[base+4][0], sign);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin
        int gap;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;

        // flag fields of the fill never read as 0 or 1
        for (int i = 0; i < MAX_VEC * FIELDS; i++) begin
            vec_mem[i] = ~32'(i);
        end
        $readmemh("exec_core_testdata.txt", vec_mem);
        while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS+2] <= 32'd1) begin
            n_vec++;
        end
        loaded = 1'b1;
        if (n_vec == 0) begin
            report_failure("no test vectors found in exec_core_testdata.txt");
        end

        repeat (3) @(negedge clk);  // three reset edges
        rst_n = 1'b1;
        check_flag("result_valid", 1'b0, result_valid);
        check_word("result", '0, result);
        check_flag("carry", 1'b0, carry);
        check_flag("zero", 1'b0, zero);
        check_flag("sign", 1'b0, sign);
        @(negedge clk);
        check_flag("result_valid", 1'b0, result_valid);  // nothing strobed yet

        for (int v = 0; v < n_vec; v++) begin
            instr       = vec_mem[v*FIELDS];
            instr_valid = 1'b1;
            @(negedge clk);
            check_vector(v);
            instr_valid = 1'b0;
            draw_bits(2, gap);
            for (int k = 0; k < gap; k++) begin
                @(negedge clk);
                check_flag("result_valid", 1'b0, result_valid);  // idle cycle
            end
        end

        $display("Testbench passed");
        $finish;
    end

    // watchdog allows 5 cycles per vector plus reset
    initial begin
        wait (loaded);
        #(n_vec * 5 * CLK_PERIOD + 200);
        report_failure($sformatf("timeout: %0d vectors did not finish in time", n_vec));
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
exec_pkg.sv
alu_if.sv
cla_adder_32.sv
alu.sv
reg_file.sv
operand_decoder.sv
writeback_reg.sv
exec_core.sv
tb_exec_core.sv

// ==== writeback_reg.sv ====
`default_nettype none

module writeback_reg
    import exec_pkg::*;
#(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    alu_if.writeback                   bus,
    input  wire logic [REG_ADDR_W-1:0] rd,
    input  wire logic                  wb_strobe,
    output logic                       we,
    output logic      [REG_ADDR_W-1:0] waddr,
    output logic      [DATA_W-1:0]     wdata,
    output logic      [DATA_W-1:0]     result,
    output logic                       result_valid,
    output logic                       carry,
    output logic                       zero,
    output logic                       sign
);

    // register write lands on the same edge as the result
    assign we    = wb_strobe && (rd != '0);
    assign waddr = rd;
    assign wdata = bus.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
            carry        <= 1'b0;
            zero         <= 1'b0;
            sign         <= 1'b0;
        end else begin
            result_valid <= wb_strobe;
            if (wb_strobe) begin
                result <= bus.result;
                zero   <= bus.zero;
                sign   <= bus.sign;
                if (bus.alu_op == OP_ADD) begin
                    carry <= bus.carry;  // held by every other op
                end
            end
        end
    end

    a_no_valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !result_valid
    ) else $error("writeback_reg: result_valid high right after reset");

endmodule

`default_nettype wire
